// ==== src/len5_defines.svh ====
// Shared width and credit macros

`ifndef LEN5_DEFINES_SVH
`define LEN5_DEFINES_SVH

// Address width, byte addressed
`define XLEN 32

// Instruction and data word width
`define ILEN 32

// L2 requests in flight at once
// Arbiter credit counter starts here
`define L2_CREDITS 2

// Instruction slots granted by the consumer after reset
`define FETCH_CREDITS 4

`endif

// ==== src/memory_pkg.sv ====
// L2 port types

`include "len5_defines.svh"

package memory_pkg;

	// Requester id, stamped by the arbiter
	typedef enum logic {
		FETCH = 1'b0,
		LSU   = 1'b1
	} l2_src_e;

	// Request toward the L2
	// Word aligned address, wdata ignored on reads
	typedef struct packed {
		l2_src_e           src;
		logic              we;
		logic [`XLEN-1:0]  addr;
		logic [`ILEN-1:0]  wdata;
	} l2_req_t;

	// Answer from the L2
	// Stores get one too, rdata is junk then
	typedef struct packed {
		l2_src_e           src;
		logic [`ILEN-1:0]  rdata;
	} l2_ans_t;

endpackage

// ==== src/expipe_pkg.sv ====
// Fetch and load/store types

`include "len5_defines.svh"

package expipe_pkg;

	// Base RISC-V field layout, R-type naming
	typedef struct packed {
		logic [6:0]  funct7;
		logic [4:0]  rs2;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} instr_fields_t;

	// Same word seen as fields or as plain data
	typedef union packed {
		instr_fields_t     fields;
		logic [`ILEN-1:0]  raw;
	} instr_u;

	// Control transfer class from the opcode
	typedef enum logic [1:0] {
		BR_NONE = 2'd0,
		BR_COND = 2'd1,
		BR_JAL  = 2'd2,
		BR_JALR = 2'd3
	} branch_type_e;

	// Word command into the load/store unit
	typedef struct packed {
		logic              store;
		logic [`XLEN-1:0]  addr;
		logic [`ILEN-1:0]  data;
	} ldst_cmd_t;

	// One fetched instruction
	typedef struct packed {
		logic [`XLEN-1:0]  pc;
		instr_u            instr;
		branch_type_e      br;
	} fetch_out_t;

endpackage

// ==== src/fetch_unit.sv ====
// Sequential instruction fetch

`include "len5_defines.svh"

module fetch_unit #(
	parameter logic [`XLEN-1:0] BOOT_PC = '0
) (
	input  logic                    clk_i,
	input  logic                    rst_n_i,
	input  logic                    flush_i,
	// Arbiter side
	output logic                    req_valid_o,
	output memory_pkg::l2_req_t     req_o,
	input  logic                    req_gnt_i,
	input  logic                    ans_valid_i,
	input  memory_pkg::l2_ans_t     ans_i,
	// Instruction consumer side
	output logic                    ins_valid_o,
	output expipe_pkg::fetch_out_t  ins_o,
	input  logic                    ins_credit_i
);

	localparam int CRED_W = $clog2(`FETCH_CREDITS + 1);

	// Opcodes of the control transfer instructions
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;

	logic [`XLEN-1:0]         pc_q;
	logic [CRED_W-1:0]        cred_q;
	logic                     busy_q;
	logic                     discard_q;
	logic                     out_fire;
	expipe_pkg::instr_u       ans_word;
	expipe_pkg::branch_type_e br_type;

	// Ask only with a free slot downstream and nothing in flight
	assign req_valid_o = (cred_q != '0) && !busy_q;
	assign req_o.src   = memory_pkg::FETCH;
	assign req_o.we    = 1'b0;
	assign req_o.addr  = pc_q;
	assign req_o.wdata = '0;

	// Answer is dropped if it belongs to a flushed request
	assign out_fire = ans_valid_i && !discard_q && !flush_i;

	// Opcode view of the returned word
	assign ans_word.raw = ans_i.rdata;

	always_comb begin
		unique case (ans_word.fields.opcode)
			OPC_BRANCH: br_type = expipe_pkg::BR_COND;
			OPC_JAL:    br_type = expipe_pkg::BR_JAL;
			OPC_JALR:   br_type = expipe_pkg::BR_JALR;
			default:    br_type = expipe_pkg::BR_NONE;
		endcase
	end

	// Pc, in-flight flag and discard flag
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pc_q      <= BOOT_PC;
			busy_q    <= 1'b0;
			discard_q <= 1'b0;
		end else begin
			if (req_gnt_i)
				busy_q <= 1'b1;
			else if (ans_valid_i)
				busy_q <= 1'b0;
			if (flush_i) begin
				pc_q <= BOOT_PC;
				// Something still due from the old stream
				discard_q <= req_gnt_i || (busy_q && !ans_valid_i);
			end else if (ans_valid_i) begin
				discard_q <= 1'b0;
				if (!discard_q)
					pc_q <= pc_q + `XLEN'(4);
			end
		end
	end

	// Output credits, one spent per instruction sent
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			cred_q <= CRED_W'(`FETCH_CREDITS);
		end else begin
			unique case ({ins_credit_i, out_fire})
				2'b10:   cred_q <= cred_q + 1'b1;
				2'b01:   cred_q <= cred_q - 1'b1;
				default: cred_q <= cred_q;
			endcase
		end
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i)
			ins_valid_o <= 1'b0;
		else
			ins_valid_o <= out_fire;
	end

	// Payload, meaningful only with ins_valid_o
	always_ff @(posedge clk_i) begin
		if (out_fire) begin
			ins_o.pc    <= pc_q;
			ins_o.instr <= ans_word;
			ins_o.br    <= br_type;
		end
	end

endmodule

// ==== src/load_store_unit.sv ====
// Word load/store engine

module load_store_unit (
	input  logic                 clk_i,
	input  logic                 rst_n_i,
	// Command side
	input  logic                 ldst_valid_i,
	input  expipe_pkg::ldst_cmd_t ldst_i,
	output logic                 ldst_done_o,
	output expipe_pkg::instr_u   ldst_data_o,
	output logic                 ldst_credit_o,
	// Arbiter side
	output logic                 req_valid_o,
	output memory_pkg::l2_req_t  req_o,
	input  logic                 req_gnt_i,
	input  logic                 ans_valid_i,
	input  memory_pkg::l2_ans_t  ans_i
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_REQ,
		S_WAIT
	} state_e;

	state_e                state_q;
	expipe_pkg::ldst_cmd_t cmd_q;
	logic                  finish;

	// Request held until the arbiter takes it
	assign req_valid_o = (state_q == S_REQ);
	assign req_o.src   = memory_pkg::LSU;
	assign req_o.we    = cmd_q.store;
	assign req_o.addr  = cmd_q.addr;
	assign req_o.wdata = cmd_q.data;

	assign finish = (state_q == S_WAIT) && ans_valid_i;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= S_IDLE;
		end else begin
			unique case (state_q)
				S_IDLE:
					if (ldst_valid_i)
						state_q <= S_REQ;
				S_REQ:
					if (req_gnt_i)
						state_q <= S_WAIT;
				S_WAIT:
					if (ans_valid_i)
						state_q <= S_IDLE;
				default:
					state_q <= S_IDLE;
			endcase
		end
	end

	// Command latched once, kept until the answer
	always_ff @(posedge clk_i) begin
		if (state_q == S_IDLE && ldst_valid_i)
			cmd_q <= ldst_i;
	end

	// Done and credit go out together
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ldst_done_o   <= 1'b0;
			ldst_credit_o <= 1'b0;
		end else begin
			ldst_done_o   <= finish;
			ldst_credit_o <= finish;
		end
	end

	// Store completions carry zero
	always_ff @(posedge clk_i) begin
		if (finish)
			ldst_data_o.raw <= cmd_q.store ? '0 : ans_i.rdata;
	end

endmodule

// ==== src/l2_arbiter.sv ====
// Round-robin L2 port arbiter

`include "len5_defines.svh"

module l2_arbiter (
	input  logic                 clk_i,
	input  logic                 rst_n_i,
	// Requesters
	input  logic                 fetch_req_valid_i,
	input  memory_pkg::l2_req_t  fetch_req_i,
	output logic                 fetch_gnt_o,
	input  logic                 lsu_req_valid_i,
	input  memory_pkg::l2_req_t  lsu_req_i,
	output logic                 lsu_gnt_o,
	// Answers back to the units
	output logic                 fetch_ans_valid_o,
	output logic                 lsu_ans_valid_o,
	output memory_pkg::l2_ans_t  ans_o,
	// L2 port
	output logic                 l2_req_valid_o,
	output memory_pkg::l2_req_t  l2_req_o,
	input  logic                 l2_credit_i,
	input  logic                 l2_ans_valid_i,
	input  memory_pkg::l2_ans_t  l2_ans_i
);

	localparam int CRED_W = $clog2(`L2_CREDITS + 1);

	logic [CRED_W-1:0]   cred_q;
	logic                has_cred;
	logic                prio_lsu_q;
	logic                any_gnt;
	memory_pkg::l2_req_t sel_req;

	assign has_cred = (cred_q != '0);

	// Priority flips to the side not served last
	assign fetch_gnt_o = has_cred && fetch_req_valid_i && (!lsu_req_valid_i || !prio_lsu_q);
	assign lsu_gnt_o   = has_cred && lsu_req_valid_i && (!fetch_req_valid_i || prio_lsu_q);
	assign any_gnt     = fetch_gnt_o || lsu_gnt_o;

	// Winner with its id forced
	always_comb begin
		if (lsu_gnt_o) begin
			sel_req     = lsu_req_i;
			sel_req.src = memory_pkg::LSU;
		end else begin
			sel_req     = fetch_req_i;
			sel_req.src = memory_pkg::FETCH;
		end
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i)
			prio_lsu_q <= 1'b0;
		else if (any_gnt)
			prio_lsu_q <= fetch_gnt_o;
	end

	// One credit per send, one back per L2 pulse
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			cred_q <= CRED_W'(`L2_CREDITS);
		end else begin
			unique case ({l2_credit_i, any_gnt})
				2'b10:   cred_q <= cred_q + 1'b1;
				2'b01:   cred_q <= cred_q - 1'b1;
				default: cred_q <= cred_q;
			endcase
		end
	end

	// Request goes out the cycle after the grant
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i)
			l2_req_valid_o <= 1'b0;
		else
			l2_req_valid_o <= any_gnt;
	end

	always_ff @(posedge clk_i) begin
		if (any_gnt)
			l2_req_o <= sel_req;
	end

	// Answers steered by id, never stalled
	assign ans_o             = l2_ans_i;
	assign fetch_ans_valid_o = l2_ans_valid_i && (l2_ans_i.src == memory_pkg::FETCH);
	assign lsu_ans_valid_o   = l2_ans_valid_i && (l2_ans_i.src == memory_pkg::LSU);

endmodule

// ==== src/cu_dp_mem.sv ====
// Fetch and load/store memory side

`include "len5_defines.svh"

module cu_dp_mem #(
	parameter logic [`XLEN-1:0] BOOT_PC = '0
) (
	input  logic                    clk_i,
	input  logic                    rst_n_i,
	input  logic                    flush_i,
	// External L2 port
	output logic                    l2_req_valid_o,
	output memory_pkg::l2_req_t     l2_req_o,
	input  logic                    l2_credit_i,
	input  logic                    l2_ans_valid_i,
	input  memory_pkg::l2_ans_t     l2_ans_i,
	// Instruction stream
	output logic                    ins_valid_o,
	output expipe_pkg::fetch_out_t  ins_o,
	input  logic                    ins_credit_i,
	// Load/store commands
	input  logic                    ldst_valid_i,
	input  expipe_pkg::ldst_cmd_t   ldst_i,
	output logic                    ldst_done_o,
	output expipe_pkg::instr_u      ldst_data_o,
	output logic                    ldst_credit_o
);

	// Fetch <-> arbiter
	logic                fetch_req_valid;
	memory_pkg::l2_req_t fetch_req;
	logic                fetch_gnt;
	logic                fetch_ans_valid;
	// LSU <-> arbiter
	logic                lsu_req_valid;
	memory_pkg::l2_req_t lsu_req;
	logic                lsu_gnt;
	logic                lsu_ans_valid;
	// Answer payload, shared by both units
	memory_pkg::l2_ans_t unit_ans;

	fetch_unit #(
		.BOOT_PC (BOOT_PC)
	) U_FETCH (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.flush_i      (flush_i),
		.req_valid_o  (fetch_req_valid),
		.req_o        (fetch_req),
		.req_gnt_i    (fetch_gnt),
		.ans_valid_i  (fetch_ans_valid),
		.ans_i        (unit_ans),
		.ins_valid_o  (ins_valid_o),
		.ins_o        (ins_o),
		.ins_credit_i (ins_credit_i)
	);

	load_store_unit U_LSU (
		.clk_i         (clk_i),
		.rst_n_i       (rst_n_i),
		.ldst_valid_i  (ldst_valid_i),
		.ldst_i        (ldst_i),
		.ldst_done_o   (ldst_done_o),
		.ldst_data_o   (ldst_data_o),
		.ldst_credit_o (ldst_credit_o),
		.req_valid_o   (lsu_req_valid),
		.req_o         (lsu_req),
		.req_gnt_i     (lsu_gnt),
		.ans_valid_i   (lsu_ans_valid),
		.ans_i         (unit_ans)
	);

	l2_arbiter U_L2_ARB (
		.clk_i             (clk_i),
		.rst_n_i           (rst_n_i),
		.fetch_req_valid_i (fetch_req_valid),
		.fetch_req_i       (fetch_req),
		.fetch_gnt_o       (fetch_gnt),
		.lsu_req_valid_i   (lsu_req_valid),
		.lsu_req_i         (lsu_req),
		.lsu_gnt_o         (lsu_gnt),
		.fetch_ans_valid_o (fetch_ans_valid),
		.lsu_ans_valid_o   (lsu_ans_valid),
		.ans_o             (unit_ans),
		.l2_req_valid_o    (l2_req_valid_o),
		.l2_req_o          (l2_req_o),
		.l2_credit_i       (l2_credit_i),
		.l2_ans_valid_i    (l2_ans_valid_i),
		.l2_ans_i          (l2_ans_i)
	);

endmodule

// ==== tb/tb_clock_gen.sv ====
// Testbench clock and reset

module tb_clock_gen (
	output logic clk_o,
	output logic rst_n_o
);

	timeunit 1ns;
	timeprecision 100ps;

	// 8 ns period
	initial begin
		clk_o = 1'b0;
		forever #4 clk_o = ~clk_o;
	end

	// Low for the first two rising edges
	initial begin
		rst_n_o = 1'b0;
		repeat (2) @(posedge clk_o);
		#1;
		rst_n_o = 1'b1;
	end

endmodule

// ==== tb/l2_memory_model.sv ====
// L2 cache emulator

`include "len5_defines.svh"

module l2_memory_model (
	input  logic                clk_i,
	input  logic                rst_n_i,
	input  logic                req_valid_i,
	input  memory_pkg::l2_req_t req_i,
	input  logic [31:0]         rand_i,
	output logic                ans_valid_o,
	output memory_pkg::l2_ans_t ans_o,
	output logic                credit_o,
	output logic [31:0]         overrun_o
);

	timeunit 1ns;
	timeprecision 100ps;

	// 4 KB of words, filled from the testbench top
	logic [`ILEN-1:0]    mem [1024];
	memory_pkg::l2_req_t pend_q[$];
	int                  due_q[$];
	int                  cycle_cnt = 0;
	int                  due;
	memory_pkg::l2_req_t head;
	logic                ans_valid_q = 1'b0;
	memory_pkg::l2_ans_t ans_q = '0;
	logic                credit_q = 1'b0;
	logic [31:0]         overrun_q = '0;

	assign ans_valid_o = ans_valid_q;
	assign ans_o       = ans_q;
	assign credit_o    = credit_q;
	assign overrun_o   = overrun_q;

	always @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pend_q.delete();
			due_q.delete();
			ans_valid_q = 1'b0;
			credit_q    = 1'b0;
			cycle_cnt   = 0;
		end else begin
			cycle_cnt = cycle_cnt + 1;
			if (req_valid_i) begin
				// Unanswered requests already at the credit limit
				if (pend_q.size() >= `L2_CREDITS) begin
					overrun_q = overrun_q + 1;
					$display("L2 model got a request with %0d already outstanding at %0t",
						pend_q.size(), $time);
				end
				if (req_i.we)
					mem[req_i.addr[11:2]] = req_i.wdata;
				// 1 to 4 cycles, answers kept in order, one per cycle
				due = cycle_cnt + 1 + int'(rand_i[1:0]);
				if (due_q.size() > 0 && due <= due_q[due_q.size() - 1])
					due = due_q[due_q.size() - 1] + 1;
				pend_q.push_back(req_i);
				due_q.push_back(due);
			end
			#1;
			ans_valid_q = 1'b0;
			credit_q    = 1'b0;
			if (due_q.size() > 0 && due_q[0] <= cycle_cnt) begin
				head        = pend_q.pop_front();
				due_q.delete(0);
				ans_q.src   = head.src;
				ans_q.rdata = mem[head.addr[11:2]];
				ans_valid_q = 1'b1;
				// Credit goes back with the answer
				credit_q    = 1'b1;
			end
		end
	end

endmodule

// ==== tb/tb_cu_dp_mem.sv ====
// Memory side testbench

`include "len5_defines.svh"

module tb_cu_dp_mem;

	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [`XLEN-1:0] BOOT_PC = 32'h0000_0200;
	localparam logic [31:0] SEED = 32'h32ae;
	localparam int WAIT_LIMIT = 2000;
	localparam int MEM_WORDS = 1024;

	logic                   clk;
	logic                   rst_n;
	logic                   flush = 1'b0;
	logic                   l2_req_valid;
	memory_pkg::l2_req_t    l2_req;
	logic                   l2_credit;
	logic                   l2_ans_valid;
	memory_pkg::l2_ans_t    l2_ans;
	logic                   ins_valid;
	expipe_pkg::fetch_out_t ins_out;
	logic                   ins_credit = 1'b0;
	logic                   ldst_valid = 1'b0;
	expipe_pkg::ldst_cmd_t  ldst_cmd = '0;
	logic                   ldst_done;
	expipe_pkg::instr_u     ldst_data;
	logic                   ldst_credit;
	logic [31:0]            overrun_cnt;

	// Reference state
	logic [`ILEN-1:0]       ref_mem [MEM_WORDS];
	logic [`XLEN-1:0]       exp_pc = BOOT_PC;
	expipe_pkg::fetch_out_t exp_ins;
	expipe_pkg::instr_u     exp_load;
	expipe_pkg::instr_u     exp_ldst_q[$];
	logic [31:0]            delay_rnd = SEED;
	logic [31:0]            stim_rnd = SEED;
	string                  test_name = "reset";
	int                     fetch_cnt = 0;
	int                     held = 0;
	int                     ldst_cred = 1;
	bit                     credit_en = 1'b1;
	bit                     give;
	bit                     timed_out = 1'b0;
	int                     fetch_err = 0;
	int                     ldst_err = 0;
	int                     flow_err = 0;

	tb_clock_gen U_CLK (
		.clk_o   (clk),
		.rst_n_o (rst_n)
	);

	l2_memory_model U_L2 (
		.clk_i       (clk),
		.rst_n_i     (rst_n),
		.req_valid_i (l2_req_valid),
		.req_i       (l2_req),
		.rand_i      (delay_rnd),
		.ans_valid_o (l2_ans_valid),
		.ans_o       (l2_ans),
		.credit_o    (l2_credit),
		.overrun_o   (overrun_cnt)
	);

	cu_dp_mem #(
		.BOOT_PC (BOOT_PC)
	) UUT (
		.clk_i          (clk),
		.rst_n_i        (rst_n),
		.flush_i        (flush),
		.l2_req_valid_o (l2_req_valid),
		.l2_req_o       (l2_req),
		.l2_credit_i    (l2_credit),
		.l2_ans_valid_i (l2_ans_valid),
		.l2_ans_i       (l2_ans),
		.ins_valid_o    (ins_valid),
		.ins_o          (ins_out),
		.ins_credit_i   (ins_credit),
		.ldst_valid_i   (ldst_valid),
		.ldst_i         (ldst_cmd),
		.ldst_done_o    (ldst_done),
		.ldst_data_o    (ldst_data),
		.ldst_credit_o  (ldst_credit)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Initial word per address, biased toward control transfer opcodes
	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		logic [31:0] w;
		w = xorshift(xorshift(SEED ^ addr));
		case (w[31:30])
			2'd0: w[6:0] = 7'b1100011;
			2'd1: w[6:0] = 7'b1101111;
			2'd2: w[6:0] = 7'b1100111;
		endcase
		return w;
	endfunction

	function automatic logic [`ILEN-1:0] ref_word(input logic [`XLEN-1:0] addr);
		return ref_mem[addr[11:2]];
	endfunction

	function automatic expipe_pkg::branch_type_e ref_branch(input expipe_pkg::instr_u instr);
		case (instr.fields.opcode)
			7'b1100011: return expipe_pkg::BR_COND;
			7'b1101111: return expipe_pkg::BR_JAL;
			7'b1100111: return expipe_pkg::BR_JALR;
			default:    return expipe_pkg::BR_NONE;
		endcase
	endfunction

	function automatic logic [`XLEN-1:0] ref_next_pc(input logic [`XLEN-1:0] pc);
		return pc + 32'd4;
	endfunction

	task automatic check_fetch(input string name, input expipe_pkg::fetch_out_t exp_v,
		input expipe_pkg::fetch_out_t act_v);
		if (act_v !== exp_v) begin
			fetch_err++;
			$display("Error %s: expected pc %h instr %h br %0d, actual pc %h instr %h br %0d",
				name, exp_v.pc, exp_v.instr.raw, exp_v.br,
				act_v.pc, act_v.instr.raw, act_v.br);
		end
	endtask

	task automatic check_load(input string name, input expipe_pkg::instr_u exp_v,
		input expipe_pkg::instr_u act_v);
		if (act_v !== exp_v) begin
			ldst_err++;
			$display("Error %s: expected data %h, actual data %h", name, exp_v.raw, act_v.raw);
		end
	endtask

	// Later waits return at once, the run goes on to the closing report
	task automatic report_timeout(input string why);
		$display("Timeout: %s", why);
		timed_out = 1'b1;
	endtask

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic wait_fetch(input int target, input string why);
		int t;
		t = 0;
		while (fetch_cnt < target && !timed_out) begin
			if (t >= WAIT_LIMIT)
				report_timeout(why);
			else
				step();
			t++;
		end
	endtask

	task automatic wait_ldst_idle();
		int t;
		t = 0;
		while (exp_ldst_q.size() != 0 && !timed_out) begin
			if (t >= WAIT_LIMIT)
				report_timeout("load/store commands never completed");
			else
				step();
			t++;
		end
	endtask

	// Waits for the command credit, records the expected result, sends
	task automatic issue_ldst(input logic store, input logic [`XLEN-1:0] addr,
		input logic [`ILEN-1:0] data);
		int t;
		expipe_pkg::instr_u exp_v;
		t = 0;
		while (ldst_cred == 0 && !timed_out) begin
			if (t >= WAIT_LIMIT)
				report_timeout("no load/store command credit came back");
			else
				step();
			t++;
		end
		if (!timed_out) begin
			ldst_cred--;
			if (store) begin
				exp_v.raw = '0;
				ref_mem[addr[11:2]] = data;
			end else begin
				exp_v.raw = ref_word(addr);
			end
			exp_ldst_q.push_back(exp_v);
			ldst_cmd.store = store;
			ldst_cmd.addr  = addr;
			ldst_cmd.data  = data;
			ldst_valid     = 1'b1;
			step();
			ldst_valid     = 1'b0;
		end
	endtask

	task automatic pulse_flush();
		flush = 1'b1;
		step();
		flush = 1'b0;
	endtask

	// New delay value every cycle for the L2 model
	always @(posedge clk) begin
		#1;
		delay_rnd = xorshift(delay_rnd);
	end

	// Instruction consumer, one credit back per instruction while enabled
	always @(posedge clk) begin
		if (ins_valid)
			held++;
		if (held > `FETCH_CREDITS) begin
			flow_err++;
			$display("Fetch sent more instructions than it had credits for at %0t", $time);
		end
		give = credit_en && (held > 0);
		if (give)
			held--;
		#1;
		ins_credit = give;
	end

	// Compares every output against the reference
	always @(posedge clk) begin
		if (rst_n) begin
			if (ins_valid) begin
				exp_ins.pc        = exp_pc;
				exp_ins.instr.raw = ref_word(exp_pc);
				exp_ins.br        = ref_branch(exp_ins.instr);
				check_fetch(test_name, exp_ins, ins_out);
				exp_pc = ref_next_pc(exp_pc);
				fetch_cnt++;
			end
			// Stream restarts after the flush edge
			if (flush)
				exp_pc = BOOT_PC;
			// Credit comes back in the done cycle
			if (ldst_credit !== ldst_done) begin
				flow_err++;
				$display("Load/store credit and done pulses not in the same cycle at %0t",
					$time);
			end
			if (ldst_done) begin
				if (exp_ldst_q.size() == 0) begin
					ldst_err++;
					$display("Load/store unit finished with no command pending at %0t", $time);
				end else begin
					exp_load = exp_ldst_q.pop_front();
					check_load(test_name, exp_load, ldst_data);
				end
			end
			if (ldst_credit)
				ldst_cred++;
		end
	end

	initial begin
		int t;
		int base;
		logic [31:0] w;
		for (int i = 0; i < MEM_WORDS; i++) begin
			w = fill_word(32'(i * 4));
			ref_mem[i] = w;
			U_L2.mem[i] = w;
		end
		t = 0;
		while (!rst_n && !timed_out) begin
			if (t >= WAIT_LIMIT)
				report_timeout("reset never released");
			else
				step();
			t++;
		end

		// Plain sequential stream
		test_name = "sequential fetch";
		wait_fetch(24, "fetch stream stopped");

		// Store then load back, and untouched words
		test_name = "store then load";
		issue_ldst(1'b1, 32'h0000_0800, 32'ha5a5_1234);
		issue_ldst(1'b0, 32'h0000_0800, '0);
		issue_ldst(1'b0, 32'h0000_0c40, '0);
		issue_ldst(1'b1, 32'h0000_0804, 32'h0bad_cafe);
		issue_ldst(1'b0, 32'h0000_0804, '0);
		wait_ldst_idle();

		// Random mix while fetch keeps running
		test_name = "contention";
		base = fetch_cnt;
		for (int i = 0; i < 40; i++) begin
			stim_rnd = xorshift(stim_rnd);
			w = xorshift(stim_rnd);
			case (stim_rnd[13:12])
				2'd0:    issue_ldst(1'b0, 32'h800 | (32'(stim_rnd[3:0]) << 2), '0);
				2'd2:    issue_ldst(1'b0, 32'hc00 | (32'(stim_rnd[11:4]) << 2), '0);
				default: issue_ldst(1'b1, 32'h800 | (32'(stim_rnd[3:0]) << 2), w);
			endcase
		end
		wait_ldst_idle();
		wait_fetch(base + 8, "fetch starved under contention");

		// Consumer stops giving credits
		test_name = "credit stall";
		credit_en = 1'b0;
		t = 0;
		while (held < `FETCH_CREDITS && !timed_out) begin
			if (t >= WAIT_LIMIT)
				report_timeout("fetch did not use up its output credits");
			else
				step();
			t++;
		end
		base = fetch_cnt;
		repeat (30) step();
		if (fetch_cnt != base) begin
			flow_err++;
			$display("Fetch kept sending instructions with no credits left");
		end
		credit_en = 1'b1;
		wait_fetch(base + 12, "fetch did not resume after credits came back");

		// Flushes at random points of the stream
		test_name = "flush";
		for (int i = 0; i < 6; i++) begin
			stim_rnd = xorshift(stim_rnd);
			repeat (int'(stim_rnd[2:0])) step();
			pulse_flush();
			wait_fetch(fetch_cnt + 3, "no instruction after flush");
		end

		wait_ldst_idle();
		if (ldst_cred != 1) begin
			flow_err++;
			$display("Load/store command credits end at %0d instead of 1", ldst_cred);
		end
		$display("Errors: fetch %0d, load/store %0d, flow %0d, L2 model %0d, timeout %0d",
			fetch_err, ldst_err, flow_err, overrun_cnt, int'(timed_out));
		if (fetch_err + ldst_err + flow_err + int'(overrun_cnt) == 0 && !timed_out)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+src
src/memory_pkg.sv
src/expipe_pkg.sv
src/fetch_unit.sv
src/load_store_unit.sv
src/l2_arbiter.sv
src/cu_dp_mem.sv
tb/tb_clock_gen.sv
tb/l2_memory_model.sv
tb/tb_cu_dp_mem.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
	--top-module tb_cu_dp_mem -f src.f -o tb_sim > build.log 2>&1 \
	&& ./obj_dir/tb_sim > sim.log 2>&1 \
	|| { echo "Build or simulation did not complete, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "Test failures found" sim.log \
	&& { echo "FAIL"; exit 1; } \
	|| { echo "PASS"; exit 0; }
